// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - hw/ex_pkg.sv
      - hw/ex_result_if.sv
      - hw/ex_alu.sv
      - hw/ex_hilo_unit.sv
      - hw/ex_result_merge.sv
      - hw/ex_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/ex_tb.sv

// File: filelist.f
+incdir+include
hw/ex_pkg.sv
hw/ex_result_if.sv
hw/ex_alu.sv
hw/ex_hilo_unit.sv
hw/ex_result_merge.sv
hw/ex_top.sv
sim/ex_tb.sv

// File: hw/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::word_t     pc_i,
    input  ex_pkg::oper_t     oper_i,
    input  ex_pkg::word_t     reg1_i,
    input  ex_pkg::word_t     reg2_i,
    input  logic              wreg_write_i,
    input  ex_pkg::reg_addr_t wreg_addr_i,
    alu_result_if.alu         res
);
    import ex_pkg::*;

    word_t add_res;
    word_t sub_res;
    word_t mul_lo;
    word_t link_addr;
    logic  signed_lt;
    logic  unsigned_lt;
    logic  [4:0] shamt;

    // wrap-around arithmetic, no overflow trap
    assign add_res = reg1_i + reg2_i;
    assign sub_res = reg1_i - reg2_i;

    // opposite signs decide directly, otherwise the difference sign does
    assign signed_lt   = (reg1_i[31] != reg2_i[31]) ? reg1_i[31] : sub_res[31];
    assign unsigned_lt = (reg1_i < reg2_i);

    // low word is the same for signed and unsigned operands
    assign mul_lo = reg1_i * reg2_i;

    // return address skips the delay slot
    assign link_addr = pc_i + 32'd8;

    assign shamt = reg1_i[4:0];

    always_comb begin
        res.wreg_write = wreg_write_i;
        res.wreg_addr  = wreg_addr_i;
        res.wreg_data  = ZERO_WORD;
        res.mem_addr   = ZERO_WORD;
        res.mem_data   = ZERO_WORD;

        case (oper_i)
            OP_AND, OP_ANDI:   res.wreg_data = reg1_i & reg2_i;
            OP_OR, OP_ORI:     res.wreg_data = reg1_i | reg2_i;
            OP_XOR, OP_XORI:   res.wreg_data = reg1_i ^ reg2_i;
            OP_NOR:            res.wreg_data = ~(reg1_i | reg2_i);
            OP_SLL, OP_SLLV:   res.wreg_data = reg2_i << shamt;
            OP_SRL, OP_SRLV:   res.wreg_data = reg2_i >> shamt;
            OP_SRA, OP_SRAV:   res.wreg_data = $signed(reg2_i) >>> shamt;
            OP_LUI:            res.wreg_data = {reg2_i[15:0], 16'h0000};

            // conditional moves drop the write when the test fails
            OP_MOVN: begin
                if (reg2_i != ZERO_WORD) begin
                    res.wreg_data = reg1_i;
                end else begin
                    res.wreg_write = 1'b0;
                end
            end
            OP_MOVZ: begin
                if (reg2_i == ZERO_WORD) begin
                    res.wreg_data = reg1_i;
                end else begin
                    res.wreg_write = 1'b0;
                end
            end

            OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU: res.wreg_data = add_res;
            OP_SUB, OP_SUBU:   res.wreg_data = sub_res;
            OP_SLT, OP_SLTI:   res.wreg_data = {31'b0, signed_lt};
            OP_SLTU, OP_SLTIU: res.wreg_data = {31'b0, unsigned_lt};
            OP_MUL:            res.wreg_data = mul_lo;

            OP_JALR:           res.wreg_data = link_addr;
            // these always link, whatever decode requested
            OP_JAL, OP_BLTZAL, OP_BGEZAL: begin
                res.wreg_write = 1'b1;
                res.wreg_data  = link_addr;
            end

            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                res.mem_addr = add_res;
            end
            OP_SB, OP_SH, OP_SW: begin
                res.mem_addr = reg1_i;
                res.mem_data = reg2_i;
            end

            // HI/LO traffic is resolved in the merge stage
            OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO: begin
                res.wreg_data = ZERO_WORD;
            end

            default: begin
                res.wreg_data = ZERO_WORD;
            end
        endcase
    end

endmodule

// File: hw/ex_hilo_unit.sv
`timescale 1ns/1ps

module ex_hilo_unit (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  ex_pkg::oper_t  oper_i,
    input  ex_pkg::word_t  reg1_i,
    input  ex_pkg::word_t  reg2_i,
    input  logic           pend_valid_i,
    input  logic           pend_whilo_i,
    input  ex_pkg::word_t  pend_hi_i,
    input  ex_pkg::word_t  pend_lo_i,
    hilo_result_if.hilo    res
);
    import ex_pkg::*;

    word_t  hi_q;
    word_t  lo_q;
    word_t  fwd_hi;
    word_t  fwd_lo;
    logic   pend_wr;
    logic   is_signed;
    logic   res_sign;
    word_t  abs_reg1;
    word_t  abs_reg2;
    dword_t mul_abs;
    dword_t mul_res;

    // write sitting in the EX/MEM register, committed on the next edge
    assign pend_wr = pend_valid_i && pend_whilo_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= ZERO_WORD;
            lo_q <= ZERO_WORD;
        end else if (pend_wr) begin
            hi_q <= pend_hi_i;
            lo_q <= pend_lo_i;
        end
    end

    // pending write wins over the stored pair
    assign fwd_hi = pend_wr ? pend_hi_i : hi_q;
    assign fwd_lo = pend_wr ? pend_lo_i : lo_q;

    // multiply magnitudes, then fix the sign
    assign is_signed = (oper_i == OP_MULT);
    assign res_sign  = is_signed && (reg1_i[31] ^ reg2_i[31]);
    assign abs_reg1  = (is_signed && reg1_i[31]) ? -reg1_i : reg1_i;
    assign abs_reg2  = (is_signed && reg2_i[31]) ? -reg2_i : reg2_i;
    assign mul_abs   = dword_t'(abs_reg1) * dword_t'(abs_reg2);
    assign mul_res   = res_sign ? -mul_abs : mul_abs;

    always_comb begin
        res.whilo   = writes_hilo(oper_i);
        res.hi      = fwd_hi;
        res.lo      = fwd_lo;
        res.rd_sel  = 1'b0;
        res.rd_data = ZERO_WORD;

        case (oper_i)
            OP_MULT, OP_MULTU: begin
                res.hi = mul_res[63:32];
                res.lo = mul_res[31:0];
            end
            // a move replaces one half, the other keeps its current value
            OP_MTHI: res.hi = reg1_i;
            OP_MTLO: res.lo = reg1_i;
            OP_MFHI: begin
                res.rd_sel  = 1'b1;
                res.rd_data = fwd_hi;
            end
            OP_MFLO: begin
                res.rd_sel  = 1'b1;
                res.rd_data = fwd_lo;
            end
            default: begin
                res.rd_sel = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/ex_pkg.sv
package ex_pkg;

    // data word and full product
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // register number, zero is the discard target
    typedef logic [4:0] reg_addr_t;

    localparam word_t     ZERO_WORD = 32'h0000_0000;
    localparam reg_addr_t REG_ZERO  = 5'd0;

    // operations handed over by decode
    typedef enum logic [5:0] {
        OP_NOP,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_ORI,
        OP_XOR,
        OP_XORI,
        OP_NOR,
        OP_SLL,
        OP_SLLV,
        OP_SRL,
        OP_SRLV,
        OP_SRA,
        OP_SRAV,
        OP_LUI,
        OP_MOVN,
        OP_MOVZ,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_ADD,
        OP_ADDI,
        OP_ADDU,
        OP_ADDIU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTI,
        OP_SLTU,
        OP_SLTIU,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_JALR,
        OP_JAL,
        OP_BLTZAL,
        OP_BGEZAL,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } oper_t;

    // operations that end in a HI/LO write instead of a register write
    function automatic logic writes_hilo(input oper_t op);
        return (op == OP_MULT) ||
               (op == OP_MULTU) ||
               (op == OP_MTHI) ||
               (op == OP_MTLO);
    endfunction

endpackage

// File: hw/ex_result_if.sv
`timescale 1ns/1ps

// integer ALU result toward the merge stage
interface alu_result_if;
    import ex_pkg::*;

    logic      wreg_write;
    reg_addr_t wreg_addr;
    word_t     wreg_data;
    word_t     mem_addr;
    word_t     mem_data;

    modport alu (output wreg_write, wreg_addr, wreg_data, mem_addr, mem_data);
    modport merge (input wreg_write, wreg_addr, wreg_data, mem_addr, mem_data);
endinterface

// HI/LO write request and MFHI/MFLO read data
interface hilo_result_if;
    import ex_pkg::*;

    logic  whilo;
    word_t hi;
    word_t lo;
    logic  rd_sel;
    word_t rd_data;

    modport hilo (output whilo, hi, lo, rd_sel, rd_data);
    modport merge (input whilo, hi, lo, rd_sel, rd_data);
endinterface

// File: hw/ex_result_merge.sv
`timescale 1ns/1ps

module ex_result_merge (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               valid_i,
    input  ex_pkg::oper_t      oper_i,
    alu_result_if.merge        alu,
    hilo_result_if.merge       hilo,
    output logic               valid_o,
    output ex_pkg::oper_t      oper_o,
    output logic               wreg_write_o,
    output ex_pkg::reg_addr_t  wreg_addr_o,
    output ex_pkg::word_t      wreg_data_o,
    output logic               whilo_o,
    output ex_pkg::word_t      hi_o,
    output ex_pkg::word_t      lo_o,
    output ex_pkg::word_t      mem_addr_o,
    output ex_pkg::word_t      mem_data_o
);
    import ex_pkg::*;

    logic      wreg_write_d;
    reg_addr_t wreg_addr_d;
    word_t     wreg_data_d;

    // pick the register write source
    always_comb begin
        wreg_write_d = alu.wreg_write;
        wreg_addr_d  = alu.wreg_addr;
        wreg_data_d  = alu.wreg_data;

        if (hilo.whilo) begin
            wreg_write_d = 1'b0;
            wreg_addr_d  = REG_ZERO;
        end else if (hilo.rd_sel) begin
            wreg_data_d = hilo.rd_data;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o      <= 1'b0;
            oper_o       <= OP_NOP;
            wreg_write_o <= 1'b0;
            whilo_o      <= 1'b0;
        end else begin
            valid_o      <= valid_i;
            oper_o       <= valid_i ? oper_i : OP_NOP;
            wreg_write_o <= valid_i && wreg_write_d;
            whilo_o      <= valid_i && hilo.whilo;
        end
    end

    // payload, zeroed in empty cycles
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wreg_addr_o <= wreg_addr_d;
            wreg_data_o <= wreg_data_d;
            hi_o        <= hilo.hi;
            lo_o        <= hilo.lo;
            mem_addr_o  <= alu.mem_addr;
            mem_data_o  <= alu.mem_data;
        end else begin
            wreg_addr_o <= REG_ZERO;
            wreg_data_o <= ZERO_WORD;
            hi_o        <= ZERO_WORD;
            lo_o        <= ZERO_WORD;
            mem_addr_o  <= ZERO_WORD;
            mem_data_o  <= ZERO_WORD;
        end
    end

endmodule

// File: hw/ex_top.sv
`timescale 1ns/1ps

module ex_top (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               valid_i,
    input  ex_pkg::word_t      pc_i,
    input  ex_pkg::oper_t      oper_i,
    input  ex_pkg::word_t      reg1_i,
    input  ex_pkg::word_t      reg2_i,
    input  logic               wreg_write_i,
    input  ex_pkg::reg_addr_t  wreg_addr_i,
    output logic               valid_o,
    output ex_pkg::oper_t      oper_o,
    output logic               wreg_write_o,
    output ex_pkg::reg_addr_t  wreg_addr_o,
    output ex_pkg::word_t      wreg_data_o,
    output logic               whilo_o,
    output ex_pkg::word_t      hi_o,
    output ex_pkg::word_t      lo_o,
    output ex_pkg::word_t      mem_addr_o,
    output ex_pkg::word_t      mem_data_o
);

    alu_result_if  i_alu_res ();
    hilo_result_if i_hilo_res ();

    ex_alu i_alu (
        .pc_i         (pc_i),
        .oper_i       (oper_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .wreg_write_i (wreg_write_i),
        .wreg_addr_i  (wreg_addr_i),
        .res          (i_alu_res)
    );

    // registered outputs double as the memory-stage HI/LO write
    ex_hilo_unit i_hilo (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .oper_i       (oper_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .pend_valid_i (valid_o),
        .pend_whilo_i (whilo_o),
        .pend_hi_i    (hi_o),
        .pend_lo_i    (lo_o),
        .res          (i_hilo_res)
    );

    ex_result_merge i_merge (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .oper_i       (oper_i),
        .alu          (i_alu_res),
        .hilo         (i_hilo_res),
        .valid_o      (valid_o),
        .oper_o       (oper_o),
        .wreg_write_o (wreg_write_o),
        .wreg_addr_o  (wreg_addr_o),
        .wreg_data_o  (wreg_data_o),
        .whilo_o      (whilo_o),
        .hi_o         (hi_o),
        .lo_o         (lo_o),
        .mem_addr_o   (mem_addr_o),
        .mem_data_o   (mem_data_o)
    );

endmodule

// File: include/ex_tb_vectors.svh
`ifndef EX_TB_VECTORS_SVH
`define EX_TB_VECTORS_SVH

task automatic load_directed_rows();
    // alu_row takes op, reg1, reg2, pc, write, addr, expected write and expected data
    alu_row(OP_AND,  'hF0F01234, 'h0FF0FF00, 'h0, 1'b1, 5'd1, 1'b1, 'h00F01200);
    alu_row(OP_OR,   'hF0000001, 'h0000F010, 'h0, 1'b1, 5'd2, 1'b1, 'hF000F011);
    alu_row(OP_XOR,  'hFFFF0000, 'h0F0F0F0F, 'h0, 1'b1, 5'd3, 1'b1, 'hF0F00F0F);
    alu_row(OP_NOR,  'h000000FF, 'hFF000000, 'h0, 1'b1, 5'd4, 1'b1, 'h00FFFF00);
    alu_row(OP_ORI,  'h00000001, 'h00000002, 'h0, 1'b0, 5'd5, 1'b0, 'h0);
    alu_row(OP_SLL,  'h00000004, 'h00001234, 'h0, 1'b1, 5'd6, 1'b1, 'h00012340);
    alu_row(OP_SRL,  'h00000008, 'h80000000, 'h0, 1'b1, 5'd7, 1'b1, 'h00800000);
    alu_row(OP_SRA,  'h00000004, 'h80000000, 'h0, 1'b1, 5'd8, 1'b1, 'hF8000000);
    // only the low five bits of reg1 count
    alu_row(OP_SRAV, 'h00000024, 'hF00000F0, 'h0, 1'b1, 5'd9, 1'b1, 'hFF00000F);
    alu_row(OP_LUI,  'h00000000, 'h0000ABCD, 'h0, 1'b1, 5'd1, 1'b1, 'hABCD0000);
    alu_row(OP_ADDU, 'hFFFFFFFF, 'h00000002, 'h0, 1'b1, 5'd2, 1'b1, 'h00000001);
    alu_row(OP_ADD,  'h7FFFFFFF, 'h00000001, 'h0, 1'b1, 5'd3, 1'b1, 'h80000000);
    alu_row(OP_SUBU, 'h00000001, 'h00000002, 'h0, 1'b1, 5'd4, 1'b1, 'hFFFFFFFF);
    alu_row(OP_SUB,  'h80000000, 'h00000001, 'h0, 1'b1, 5'd5, 1'b1, 'h7FFFFFFF);
    alu_row(OP_SLT,  'hFFFFFFFF, 'h00000001, 'h0, 1'b1, 5'd6, 1'b1, 'h00000001);
    alu_row(OP_SLTU, 'hFFFFFFFF, 'h00000001, 'h0, 1'b1, 5'd7, 1'b1, 'h00000000);
    alu_row(OP_SLT,  'h00000001, 'hFFFFFFFF, 'h0, 1'b1, 5'd8, 1'b1, 'h00000000);
    alu_row(OP_SLTU, 'h00000001, 'hFFFFFFFF, 'h0, 1'b1, 5'd9, 1'b1, 'h00000001);
    alu_row(OP_MOVN, 'h12345678, 'h00000001, 'h0, 1'b1, 5'd1, 1'b1, 'h12345678);
    alu_row(OP_MOVN, 'h12345678, 'h00000000, 'h0, 1'b1, 5'd2, 1'b0, 'h0);
    alu_row(OP_MOVZ, 'hCAFE0001, 'h00000000, 'h0, 1'b1, 5'd3, 1'b1, 'hCAFE0001);
    alu_row(OP_MOVZ, 'hCAFE0001, 'h00000005, 'h0, 1'b1, 5'd4, 1'b0, 'h0);
    alu_row(OP_JAL,  'h00000000, 'h00000000, 'h00001000, 1'b0, 5'd31, 1'b1, 'h00001008);
    alu_row(OP_MUL,  'hFFFFFFFE, 'h00000003, 'h0, 1'b1, 5'd5, 1'b1, 'hFFFFFFFA);

    // signed -2 times 3 and unsigned 0xFFFFFFFE times 5, each read back at once
    hilo_row(OP_MULT,  'hFFFFFFFE, 'h00000003, 'hFFFFFFFF, 'hFFFFFFFA);
    alu_row(OP_MFHI, 'h0, 'h0, 'h0, 1'b1, 5'd6, 1'b1, 'hFFFFFFFF);
    alu_row(OP_MFLO, 'h0, 'h0, 'h0, 1'b1, 5'd7, 1'b1, 'hFFFFFFFA);
    hilo_row(OP_MULTU, 'hFFFFFFFE, 'h00000005, 'h00000004, 'hFFFFFFF6);
    alu_row(OP_MFHI, 'h0, 'h0, 'h0, 1'b1, 5'd6, 1'b1, 'h00000004);
    alu_row(OP_MFLO, 'h0, 'h0, 'h0, 1'b1, 5'd7, 1'b1, 'hFFFFFFF6);
    hilo_row(OP_MTHI,  'h13579BDF, 'h00000000, 'h13579BDF, 'hFFFFFFF6);
    alu_row(OP_MFHI, 'h0, 'h0, 'h0, 1'b1, 5'd6, 1'b1, 'h13579BDF);
    alu_row(OP_MFLO, 'h0, 'h0, 'h0, 1'b1, 5'd7, 1'b1, 'hFFFFFFF6);
    hilo_row(OP_MTLO,  'h2468ACE0, 'h00000000, 'h13579BDF, 'h2468ACE0);
    alu_row(OP_MFLO, 'h0, 'h0, 'h0, 1'b1, 5'd7, 1'b1, 'h2468ACE0);

    // mem_row takes op, reg1, reg2, write, addr, expected address and expected data
    mem_row(OP_LW, 'h00001000, 'h00000024, 1'b1, 5'd3, 'h00001024, 'h0);
    mem_row(OP_LB, 'h00002000, 'hFFFFFFFC, 1'b1, 5'd4, 'h00001FFC, 'h0);
    mem_row(OP_SW, 'h00003000, 'hDEADBEEF, 1'b0, 5'd0, 'h00003000, 'hDEADBEEF);
    mem_row(OP_SB, 'h00003001, 'h000000A5, 1'b0, 5'd0, 'h00003001, 'h000000A5);
endtask

`endif

// File: sim/ex_tb.sv
`timescale 1ns/1ps

module ex_tb;
    import ex_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 10;
    localparam int          RANDOM_ROWS  = 24;
    localparam logic [15:0] LFSR_SEED    = 16'd20;

    // one instruction with the outputs it should produce a cycle later
    typedef struct packed {
        oper_t     op;
        word_t     r1;
        word_t     r2;
        word_t     pc;
        logic      we;
        reg_addr_t wa;
        logic      exp_we;
        word_t     exp_data;
        logic      exp_whilo;
        word_t     exp_hi;
        word_t     exp_lo;
        word_t     exp_maddr;
        word_t     exp_mdata;
    } vec_t;

    logic      clk_i;
    logic      arst_n_i;
    logic      valid_i;
    word_t     pc_i;
    oper_t     oper_i;
    word_t     reg1_i;
    word_t     reg2_i;
    logic      wreg_write_i;
    reg_addr_t wreg_addr_i;
    logic      valid_o;
    oper_t     oper_o;
    logic      wreg_write_o;
    reg_addr_t wreg_addr_o;
    word_t     wreg_data_o;
    logic      whilo_o;
    word_t     hi_o;
    word_t     lo_o;
    word_t     mem_addr_o;
    word_t     mem_data_o;

    vec_t        vecs[$];
    logic [15:0] lfsr_state;
    logic        rows_ready;
    int          checks;
    int          errors;
    int          row_errs;

    ex_top i_ex_top (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .pc_i         (pc_i),
        .oper_i       (oper_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .wreg_write_i (wreg_write_i),
        .wreg_addr_i  (wreg_addr_i),
        .valid_o      (valid_o),
        .oper_o       (oper_o),
        .wreg_write_o (wreg_write_o),
        .wreg_addr_o  (wreg_addr_o),
        .wreg_data_o  (wreg_data_o),
        .whilo_o      (whilo_o),
        .hi_o         (hi_o),
        .lo_o         (lo_o),
        .mem_addr_o   (mem_addr_o),
        .mem_data_o   (mem_data_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_word(output word_t w);
        int b;
        for (b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[b] = lfsr_state[0];
        end
    endtask

    task automatic alu_row(input oper_t op, input word_t r1, input word_t r2, input word_t pc,
                           input logic we, input reg_addr_t wa,
                           input logic exp_we, input word_t exp_data);
        vec_t v;
        v = '0;
        v.op = op;
        v.r1 = r1;
        v.r2 = r2;
        v.pc = pc;
        v.we = we;
        v.wa = wa;
        v.exp_we = exp_we;
        v.exp_data = exp_data;
        vecs.push_back(v);
    endtask

    // HI/LO writers ask for a register write that must be dropped
    task automatic hilo_row(input oper_t op, input word_t r1, input word_t r2,
                            input word_t exp_hi, input word_t exp_lo);
        vec_t v;
        v = '0;
        v.op = op;
        v.r1 = r1;
        v.r2 = r2;
        v.we = 1'b1;
        v.wa = 5'd4;
        v.exp_whilo = 1'b1;
        v.exp_hi = exp_hi;
        v.exp_lo = exp_lo;
        vecs.push_back(v);
    endtask

    task automatic mem_row(input oper_t op, input word_t r1, input word_t r2,
                           input logic we, input reg_addr_t wa,
                           input word_t exp_maddr, input word_t exp_mdata);
        vec_t v;
        v = '0;
        v.op = op;
        v.r1 = r1;
        v.r2 = r2;
        v.we = we;
        v.wa = wa;
        v.exp_we = we;
        v.exp_maddr = exp_maddr;
        v.exp_mdata = exp_mdata;
        vecs.push_back(v);
    endtask

    `include "ex_tb_vectors.svh"

    task automatic add_random_rows(input int n);
        word_t a;
        word_t b;
        int    i;
        for (i = 0; i < n; i++) begin
            rand_word(a);
            rand_word(b);
            case (i % 3)
                0:       alu_row(OP_ADDU, a, b, 'h0, 1'b1, 5'd10, 1'b1, a + b);
                1:       alu_row(OP_XOR, a, b, 'h0, 1'b1, 5'd11, 1'b1, a ^ b);
                default: alu_row(OP_SLTU, a, b, 'h0, 1'b1, 5'd12, 1'b1, (a < b) ? 'h1 : 'h0);
            endcase
        end
    endtask

    task automatic drive_row(input vec_t v);
        valid_i      = 1'b1;
        oper_i       = v.op;
        reg1_i       = v.r1;
        reg2_i       = v.r2;
        pc_i         = v.pc;
        wreg_write_i = v.we;
        wreg_addr_i  = v.wa;
    endtask

    task automatic drive_idle();
        valid_i      = 1'b0;
        oper_i       = OP_NOP;
        reg1_i       = '0;
        reg2_i       = '0;
        pc_i         = '0;
        wreg_write_i = 1'b0;
        wreg_addr_i  = '0;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            row_errs++;
        end
    endtask

    task automatic check_idle(input string label);
        row_errs = 0;
        check_value("valid_o", word_t'(valid_o), 'h0);
        check_value("wreg_write_o", word_t'(wreg_write_o), 'h0);
        check_value("whilo_o", word_t'(whilo_o), 'h0);
        // empty cycles also clear the payload
        check_value("wreg_addr_o", word_t'(wreg_addr_o), 'h0);
        check_value("wreg_data_o", wreg_data_o, 'h0);
        check_value("hi_o", hi_o, 'h0);
        check_value("lo_o", lo_o, 'h0);
        check_value("mem_addr_o", mem_addr_o, 'h0);
        check_value("mem_data_o", mem_data_o, 'h0);
        $display("%s: %s", label, (row_errs == 0) ? "ok" : "failed");
    endtask

    task automatic check_row(input int idx, input vec_t v);
        oper_t op;
        op = v.op;
        row_errs = 0;
        check_value("valid_o", word_t'(valid_o), 'h1);
        check_value("oper_o", word_t'(oper_o), word_t'(op));
        check_value("wreg_write_o", word_t'(wreg_write_o), word_t'(v.exp_we));
        check_value("whilo_o", word_t'(whilo_o), word_t'(v.exp_whilo));
        if (v.exp_we) begin
            check_value("wreg_addr_o", word_t'(wreg_addr_o), word_t'(v.wa));
            check_value("wreg_data_o", wreg_data_o, v.exp_data);
        end
        if (v.exp_whilo) begin
            // a HI/LO write targets register zero
            check_value("wreg_addr_o", word_t'(wreg_addr_o), 'h0);
            check_value("hi_o", hi_o, v.exp_hi);
            check_value("lo_o", lo_o, v.exp_lo);
        end
        check_value("mem_addr_o", mem_addr_o, v.exp_maddr);
        check_value("mem_data_o", mem_data_o, v.exp_mdata);
        $display("row %0d %s: %s", idx, op.name(), (row_errs == 0) ? "ok" : "failed");
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 10);
        clk_i      = 1'b0;
        arst_n_i   = 1'b0;
        drive_idle();
        lfsr_state = LFSR_SEED;
        rows_ready = 1'b0;
        checks     = 0;
        errors     = 0;
        row_errs   = 0;

        load_directed_rows();
        add_random_rows(RANDOM_ROWS);
        rows_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #5;
        check_idle("in reset");
        arst_n_i = 1'b1;
        @(posedge clk_i);
        #5;
        check_idle("idle after reset");

        // rows go back-to-back and each is checked one cycle after it is applied
        foreach (vecs[i]) begin
            drive_row(vecs[i]);
            @(posedge clk_i);
            #5;
            check_row(i, vecs[i]);
        end

        drive_idle();
        @(posedge clk_i);
        #5;
        check_idle("idle after rows");

        $display("%0d rows, %0d checks, %0d errors", vecs.size(), checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog sized from the number of rows
    initial begin
        wait (rows_ready === 1'b1);
        #(CLK_PERIOD * (vecs.size() + 20));
        $display("timeout: the run did not end within %0d clock periods", vecs.size() + 20);
        $display("Something failed");
        $finish;
    end

endmodule
